//--- hw/axi_wmux_pkg.sv
// Widths, transaction types, decision FIFO depth and AW lock states of the write mux
`default_nettype none

package axi_wmux_pkg;

  // ------------------------------------------------------------
  // Port and ID geometry
  // ------------------------------------------------------------
  localparam int unsigned NUM_PORTS  = 4;                     // Slave ports merged
  localparam int unsigned PORT_IDX_W = 2;                     // Bits to name one port
  localparam int unsigned SLV_ID_W   = 4;                     // ID width seen by masters
  localparam int unsigned MST_ID_W   = SLV_ID_W + PORT_IDX_W; // Port index on top of ID

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Writes whose W data may still be outstanding
  localparam int unsigned MAX_W_TRANS = 8;
  localparam int unsigned CNT_W       = 4;  // Holds 0 .. MAX_W_TRANS

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;   // {port, slave ID}
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [1:0]            resp_t;     // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [CNT_W-1:0]      cnt_t;

  typedef enum logic {
    AW_IDLE,    // Forward arbiter output directly
    AW_LOCKED   // Stalled AW already pushed, hold it
  } aw_lock_state_e;

endpackage

`default_nettype wire

//--- hw/aw_rr_arbiter.sv
// Round-robin AW arbiter with lock-in and port index prepended to the ID
`timescale 1ns/1ps
`default_nettype none

module aw_rr_arbiter (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  logic                    [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_valid_i,
  input  axi_wmux_pkg::slv_id_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_id_i,
  input  axi_wmux_pkg::addr_t     [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_addr_i,
  output logic                    [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_ready_o,
  output logic                                               arb_valid_o,
  output axi_wmux_pkg::mst_id_t                              arb_id_o,
  output axi_wmux_pkg::addr_t                                arb_addr_o,
  input  logic                                               arb_ready_i
);

  axi_wmux_pkg::port_idx_t rr_ptr_q;    // Port with highest priority
  axi_wmux_pkg::port_idx_t lock_idx_q;  // Port held while its request waits
  logic                    lock_q;

  axi_wmux_pkg::port_idx_t cand_idx;
  axi_wmux_pkg::port_idx_t search_idx;
  logic                    search_hit;
  axi_wmux_pkg::port_idx_t sel_idx;

  // ------------------------------------------------------------
  // Priority search starting at the pointer
  // ------------------------------------------------------------
  // Walk from the farthest offset down, so the nearest requester wins
  always_comb begin
    search_hit = 1'b0;
    search_idx = rr_ptr_q;
    cand_idx   = rr_ptr_q;
    for (int off = axi_wmux_pkg::NUM_PORTS - 1; off >= 0; off--) begin
      cand_idx = rr_ptr_q + axi_wmux_pkg::port_idx_t'(off);  // Wraps at NUM_PORTS
      if (slv_aw_valid_i[cand_idx]) begin
        search_idx = cand_idx;
        search_hit = 1'b1;
      end
    end
  end

  // Lock-in keeps the stalled choice even if others start requesting
  assign sel_idx     = lock_q ? lock_idx_q : search_idx;
  assign arb_valid_o = lock_q ? slv_aw_valid_i[lock_idx_q] : search_hit;
  assign arb_id_o    = {sel_idx, slv_aw_id_i[sel_idx]};  // Prepend port index
  assign arb_addr_o  = slv_aw_addr_i[sel_idx];

  always_comb begin
    slv_aw_ready_o          = '0;
    slv_aw_ready_o[sel_idx] = arb_valid_o & arb_ready_i;  // Only granted port sees ready
  end

  // ------------------------------------------------------------
  // Pointer and lock registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q   <= '0;  // Port 0 first after reset
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (arb_valid_o) begin
      if (arb_ready_i) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= sel_idx + 1'b1;  // Move past the grant
      end else begin
        lock_q     <= 1'b1;          // Stall, hold this port
        lock_idx_q <= sel_idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/aw_lock_fsm.sv
// AW lock state machine holding master AW valid and pushing routing decisions
`timescale 1ns/1ps
`default_nettype none

module aw_lock_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic arb_valid_i,
  output logic arb_ready_o,
  input  logic fifo_full_i,
  output logic fifo_push_o,
  input  logic mst_aw_ready_i,
  output logic mst_aw_valid_o
);

  axi_wmux_pkg::aw_lock_state_e state_q, state_d;

  // ------------------------------------------------------------
  // Next state and handshake
  // ------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    arb_ready_o    = 1'b0;
    fifo_push_o    = 1'b0;
    mst_aw_valid_o = 1'b0;
    case (state_q)
      axi_wmux_pkg::AW_IDLE: begin
        // No new AW while the decision FIFO has no room
        if (arb_valid_i && !fifo_full_i) begin
          mst_aw_valid_o = 1'b1;
          fifo_push_o    = 1'b1;          // Decision recorded on first presentation
          arb_ready_o    = mst_aw_ready_i;
          if (!mst_aw_ready_i) state_d = axi_wmux_pkg::AW_LOCKED;
        end
      end
      axi_wmux_pkg::AW_LOCKED: begin
        mst_aw_valid_o = 1'b1;            // Valid may not drop before ready
        arb_ready_o    = mst_aw_ready_i;  // Already pushed, no second push
        if (mst_aw_ready_i) state_d = axi_wmux_pkg::AW_IDLE;
      end
      default: state_d = axi_wmux_pkg::AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_q <= axi_wmux_pkg::AW_IDLE;
    else         state_q <= state_d;
  end

endmodule

`default_nettype wire

//--- hw/w_route_fifo.sv
// Decision FIFO of port indices with occupancy counter and full/empty flags
`timescale 1ns/1ps
`default_nettype none

module w_route_fifo (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    push_i,
  input  axi_wmux_pkg::port_idx_t push_idx_i,
  input  logic                    pop_i,
  output axi_wmux_pkg::port_idx_t head_idx_o,
  output logic                    empty_o,
  output logic                    full_o
);

  typedef logic [$clog2(axi_wmux_pkg::MAX_W_TRANS)-1:0] ptr_t;

  axi_wmux_pkg::port_idx_t mem_q [axi_wmux_pkg::MAX_W_TRANS];  // Switching order
  ptr_t                    wr_ptr_q;
  ptr_t                    rd_ptr_q;
  axi_wmux_pkg::cnt_t      cnt_q;   // Entries in flight

  logic do_push;
  logic do_pop;

  // ------------------------------------------------------------
  // Flags
  // ------------------------------------------------------------
  assign full_o  = (cnt_q == axi_wmux_pkg::cnt_t'(axi_wmux_pkg::MAX_W_TRANS));
  assign empty_o = (cnt_q == '0);

  assign do_push = push_i & ~full_o;   // Overflow guard
  assign do_pop  = pop_i & ~empty_o;   // Underflow guard

  assign head_idx_o = mem_q[rd_ptr_q]; // Oldest decision

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_idx_i;
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(axi_wmux_pkg::MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(axi_wmux_pkg::MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (do_push && !do_pop)      cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/w_b_steer.sv
// W beat steering from the decision FIFO head and B response return by ID
`timescale 1ns/1ps
`default_nettype none

module w_b_steer (
  // Decision FIFO
  input  axi_wmux_pkg::port_idx_t                               head_idx_i,
  input  logic                                                  fifo_empty_i,
  output logic                                                  fifo_pop_o,
  // Slave W
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0]   slv_w_valid_i,
  input  axi_wmux_pkg::data_t   [axi_wmux_pkg::NUM_PORTS-1:0]   slv_w_data_i,
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0]   slv_w_last_i,
  output logic                  [axi_wmux_pkg::NUM_PORTS-1:0]   slv_w_ready_o,
  // Master W
  output logic                                                  mst_w_valid_o,
  output axi_wmux_pkg::data_t                                   mst_w_data_o,
  output logic                                                  mst_w_last_o,
  input  logic                                                  mst_w_ready_i,
  // Master B
  input  logic                                                  mst_b_valid_i,
  input  axi_wmux_pkg::mst_id_t                                 mst_b_id_i,
  input  axi_wmux_pkg::resp_t                                   mst_b_resp_i,
  output logic                                                  mst_b_ready_o,
  // Slave B
  output logic                  [axi_wmux_pkg::NUM_PORTS-1:0]   slv_b_valid_o,
  output axi_wmux_pkg::slv_id_t [axi_wmux_pkg::NUM_PORTS-1:0]   slv_b_id_o,
  output axi_wmux_pkg::resp_t   [axi_wmux_pkg::NUM_PORTS-1:0]   slv_b_resp_o,
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0]   slv_b_ready_i
);

  axi_wmux_pkg::port_idx_t b_port;  // Upper ID bits
  axi_wmux_pkg::slv_id_t   b_sid;   // Original ID

  // ------------------------------------------------------------
  // W channel
  // ------------------------------------------------------------
  assign mst_w_data_o = slv_w_data_i[head_idx_i];  // Payload muxed without gating
  assign mst_w_last_o = slv_w_last_i[head_idx_i];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    if (!fifo_empty_i) begin                       // Only ports with a granted AW
      mst_w_valid_o             = slv_w_valid_i[head_idx_i];
      slv_w_ready_o[head_idx_i] = mst_w_ready_i;
    end
  end

  assign fifo_pop_o = mst_w_valid_o & mst_w_ready_i & mst_w_last_o;  // End of burst

  // ------------------------------------------------------------
  // B channel
  // ------------------------------------------------------------
  assign b_port = mst_b_id_i[axi_wmux_pkg::MST_ID_W-1 -: axi_wmux_pkg::PORT_IDX_W];
  assign b_sid  = mst_b_id_i[axi_wmux_pkg::SLV_ID_W-1:0];

  always_comb begin
    slv_b_valid_o = '0;
    for (int p = 0; p < axi_wmux_pkg::NUM_PORTS; p++) begin
      slv_b_id_o[p]   = b_sid;         // Broadcast, valid picks the port
      slv_b_resp_o[p] = mst_b_resp_i;
    end
    slv_b_valid_o[b_port] = mst_b_valid_i;
  end

  assign mst_b_ready_o = slv_b_ready_i[b_port];

endmodule

`default_nettype wire

//--- hw/axi_wmux_top.sv
// Top level of the write mux joining arbiter, AW lock FSM, decision FIFO and W/B steering
`timescale 1ns/1ps
`default_nettype none

module axi_wmux_top (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  // Slave ports
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_valid_i,
  input  axi_wmux_pkg::slv_id_t [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_id_i,
  input  axi_wmux_pkg::addr_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_addr_i,
  output logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_ready_o,
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_valid_i,
  input  axi_wmux_pkg::data_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_data_i,
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_last_i,
  output logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_ready_o,
  output logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_valid_o,
  output axi_wmux_pkg::slv_id_t [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_id_o,
  output axi_wmux_pkg::resp_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_resp_o,
  input  logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_ready_i,
  // Master port
  output logic                                                mst_aw_valid_o,
  output axi_wmux_pkg::mst_id_t                               mst_aw_id_o,
  output axi_wmux_pkg::addr_t                                 mst_aw_addr_o,
  input  logic                                                mst_aw_ready_i,
  output logic                                                mst_w_valid_o,
  output axi_wmux_pkg::data_t                                 mst_w_data_o,
  output logic                                                mst_w_last_o,
  input  logic                                                mst_w_ready_i,
  input  logic                                                mst_b_valid_i,
  input  axi_wmux_pkg::mst_id_t                               mst_b_id_i,
  input  axi_wmux_pkg::resp_t                                 mst_b_resp_i,
  output logic                                                mst_b_ready_o
);

  logic                    arb_valid, arb_ready;
  logic                    fifo_push, fifo_pop;
  logic                    fifo_empty, fifo_full;
  axi_wmux_pkg::port_idx_t head_idx;   // Port owning the current W burst

  // AW path, arbiter payload goes straight to the master port
  aw_rr_arbiter i_arbiter (
    .clk_i(clk_i), .reset_i(reset_i),
    .slv_aw_valid_i(slv_aw_valid_i), .slv_aw_id_i(slv_aw_id_i),
    .slv_aw_addr_i(slv_aw_addr_i), .slv_aw_ready_o(slv_aw_ready_o),
    .arb_valid_o(arb_valid), .arb_id_o(mst_aw_id_o),
    .arb_addr_o(mst_aw_addr_o), .arb_ready_i(arb_ready)
  );

  aw_lock_fsm i_aw_lock (
    .clk_i(clk_i), .reset_i(reset_i),
    .arb_valid_i(arb_valid), .arb_ready_o(arb_ready),
    .fifo_full_i(fifo_full), .fifo_push_o(fifo_push),
    .mst_aw_ready_i(mst_aw_ready_i), .mst_aw_valid_o(mst_aw_valid_o)
  );

  // Port field of the prefixed ID is the switching decision
  w_route_fifo i_w_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .push_i(fifo_push),
    .push_idx_i(mst_aw_id_o[axi_wmux_pkg::MST_ID_W-1 -: axi_wmux_pkg::PORT_IDX_W]),
    .pop_i(fifo_pop), .head_idx_o(head_idx),
    .empty_o(fifo_empty), .full_o(fifo_full)
  );

  w_b_steer i_steer (
    .head_idx_i(head_idx), .fifo_empty_i(fifo_empty), .fifo_pop_o(fifo_pop),
    .slv_w_valid_i(slv_w_valid_i), .slv_w_data_i(slv_w_data_i),
    .slv_w_last_i(slv_w_last_i), .slv_w_ready_o(slv_w_ready_o),
    .mst_w_valid_o(mst_w_valid_o), .mst_w_data_o(mst_w_data_o),
    .mst_w_last_o(mst_w_last_o), .mst_w_ready_i(mst_w_ready_i),
    .mst_b_valid_i(mst_b_valid_i), .mst_b_id_i(mst_b_id_i),
    .mst_b_resp_i(mst_b_resp_i), .mst_b_ready_o(mst_b_ready_o),
    .slv_b_valid_o(slv_b_valid_o), .slv_b_id_o(slv_b_id_o),
    .slv_b_resp_o(slv_b_resp_o), .slv_b_ready_i(slv_b_ready_i)
  );

endmodule

`default_nettype wire

//--- bench/axi_wmux_checker.sv
// Bound protocol assertions on the write mux top-level ports
`timescale 1ns/1ps
`default_nettype none

module axi_wmux_checker (
  input logic                                                clk_i,
  input logic                                                reset_i,
  input logic                                                mst_aw_valid_o,
  input logic                                                mst_aw_ready_i,
  input axi_wmux_pkg::mst_id_t                               mst_aw_id_o,
  input axi_wmux_pkg::addr_t                                 mst_aw_addr_o,
  input logic                                                mst_w_valid_o,
  input logic                  [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_valid_o
);

  // ------------------------------------------------------------
  // AW held stable until accepted
  // ------------------------------------------------------------
  aw_stable_a : assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_valid_o && !mst_aw_ready_i |=>
      mst_aw_valid_o && $stable(mst_aw_id_o) && $stable(mst_aw_addr_o))
    else $error("AW dropped or changed while stalled");

  b_onehot_a : assert property (@(posedge clk_i) $onehot0(slv_b_valid_o))  // One B target
    else $error("More than one slave B valid");

  // Nothing leaves the mux while reset is held
  reset_quiet_a : assert property (@(posedge clk_i)
    reset_i |-> !mst_aw_valid_o && !mst_w_valid_o && (slv_b_valid_o == '0))
    else $error("Output valid high during reset");

endmodule

bind axi_wmux_top axi_wmux_checker i_checker (.*);

`default_nettype wire

//--- bench/axi_wmux_tb.sv
// Table-driven testbench for the write mux acting as four masters and the downstream slave
`timescale 1ns/1ps
`default_nettype none

module axi_wmux_tb;

  localparam int unsigned N_ENT    = 10;       // Table entries
  localparam int unsigned SEED     = 32'h954d;
  localparam int unsigned HOLD_CYC = 20;       // Cycles of W held back once the FIFO is full
  localparam int unsigned PERIOD   = 40;
  localparam int unsigned NP       = axi_wmux_pkg::NUM_PORTS;

  typedef struct packed {
    axi_wmux_pkg::port_idx_t port;
    axi_wmux_pkg::slv_id_t   sid;
    axi_wmux_pkg::addr_t     addr;
    logic [2:0]              beats;  // 1 .. 4
    axi_wmux_pkg::resp_t     resp;
  } entry_t;

  logic clk_i = 1'b0;
  logic reset_i;
  logic                  [NP-1:0] slv_aw_valid_i, slv_aw_ready_o;
  axi_wmux_pkg::slv_id_t [NP-1:0] slv_aw_id_i;
  axi_wmux_pkg::addr_t   [NP-1:0] slv_aw_addr_i;
  logic                  [NP-1:0] slv_w_valid_i, slv_w_last_i, slv_w_ready_o;
  axi_wmux_pkg::data_t   [NP-1:0] slv_w_data_i;
  logic                  [NP-1:0] slv_b_valid_o, slv_b_ready_i;
  axi_wmux_pkg::slv_id_t [NP-1:0] slv_b_id_o;
  axi_wmux_pkg::resp_t   [NP-1:0] slv_b_resp_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_last_o, mst_w_ready_i;
  logic mst_b_valid_i, mst_b_ready_o;
  axi_wmux_pkg::mst_id_t mst_aw_id_o, mst_b_id_i;
  axi_wmux_pkg::addr_t   mst_aw_addr_o;
  axi_wmux_pkg::data_t   mst_w_data_o;
  axi_wmux_pkg::resp_t   mst_b_resp_i;

  entry_t                tbl [N_ENT];
  axi_wmux_pkg::data_t   wdata [N_ENT][4];
  axi_wmux_pkg::mst_id_t seen_id [N_ENT];  // Master IDs as issued
  bit                    aw_done [N_ENT];
  int port_aw [NP];    // Next entry awaiting AW per port
  int port_w [NP];     // Entry whose W is being sent per port
  int port_beat [NP];
  int b_q [$];         // Entries owed a B response
  int errors = 0, pass_cnt = 0, tests = 0, err_mark = 0;
  int aw_cnt = 0, w_ent = 0, w_beat = 0, b_cnt = 0, hold_cnt = 0;
  bit w_release = 1'b0;

  axi_wmux_top UUT (.*);

  always #(PERIOD/2) clk_i = ~clk_i;

  // Watchdog sized from the table length
  initial begin
    #(PERIOD * N_ENT * 200);
    $display("Timeout: the writes did not complete in time");
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic chk_mid(string name, axi_wmux_pkg::mst_id_t got, axi_wmux_pkg::mst_id_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_sid(string name, axi_wmux_pkg::slv_id_t got, axi_wmux_pkg::slv_id_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_addr(string name, axi_wmux_pkg::addr_t got, axi_wmux_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_data(string name, axi_wmux_pkg::data_t got, axi_wmux_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_port(string name, axi_wmux_pkg::port_idx_t got,
                          axi_wmux_pkg::port_idx_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_resp(string name, axi_wmux_pkg::resp_t got, axi_wmux_pkg::resp_t exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic chk_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic fail_note(string what);
    $display("%0t ns: %s", $time, what);
    errors++;
  endtask

  // First table entry of port p at or after index from
  function automatic int next_ent(int p, int from);
    for (int e = from; e < N_ENT; e++) if (int'(tbl[e].port) == p) return e;
    return N_ENT;
  endfunction

  function automatic int set_bit(logic [NP-1:0] v);  // Lowest set bit, -1 if none
    for (int p = 0; p < NP; p++) if (v[p]) return p;
    return -1;
  endfunction

  // ------------------------------------------------------------
  // Falling-edge drive, sampled 1 ns later
  // ------------------------------------------------------------
  task automatic drive_inputs();
    int e;
    for (int p = 0; p < NP; p++) begin
      e = port_aw[p];
      slv_aw_valid_i[p] = (e < N_ENT);
      slv_aw_id_i[p]    = (e < N_ENT) ? tbl[e].sid : '0;
      slv_aw_addr_i[p]  = (e < N_ENT) ? tbl[e].addr : '0;
      e = port_w[p];
      slv_w_valid_i[p]  = w_release && (e < N_ENT) && aw_done[e];
      slv_w_data_i[p]   = (e < N_ENT) ? wdata[e][port_beat[p]] : '0;
      slv_w_last_i[p]   = (e < N_ENT) && (port_beat[p] == int'(tbl[e].beats) - 1);
      slv_b_ready_i[p]  = ($urandom % 2 == 0);  // Random B back-pressure per port
    end
    // First round always ready, random AW back-pressure after it
    mst_aw_ready_i = (aw_cnt < NP) || ($urandom % 2 == 0);
    mst_w_ready_i = w_release && ($urandom % 4 != 0);  // Random W back-pressure
    mst_b_valid_i = (b_q.size() > 0);
    mst_b_id_i    = mst_b_valid_i ? seen_id[b_q[0]] : '0;
    mst_b_resp_i  = mst_b_valid_i ? tbl[b_q[0]].resp : '0;
  endtask

  task automatic observe();
    int g;
    int e;
    if (!w_release && aw_cnt == axi_wmux_pkg::MAX_W_TRANS) begin  // FIFO full, W withheld
      if (mst_aw_valid_o) fail_note("AW issued while the decision FIFO was full");
      hold_cnt++;
      if (hold_cnt == HOLD_CYC) begin
        w_release = 1'b1;
        tests++;
        if (errors == err_mark) pass_cnt++;
        $display("test fifo_full: %s", (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
      end
    end
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      g = set_bit(slv_aw_ready_o);
      if (aw_cnt >= N_ENT || g < 0) fail_note("AW accepted with no matching request");
      else begin
        chk_port("granted port", axi_wmux_pkg::port_idx_t'(g), tbl[aw_cnt].port);
        chk_mid("mst_aw_id_o", mst_aw_id_o, {tbl[aw_cnt].port, tbl[aw_cnt].sid});
        chk_addr("mst_aw_addr_o", mst_aw_addr_o, tbl[aw_cnt].addr);
        seen_id[port_aw[g]] = mst_aw_id_o;
        aw_done[port_aw[g]] = 1'b1;
        port_aw[g] = next_ent(g, port_aw[g] + 1);
        aw_cnt++;
      end
    end
    if (mst_w_valid_o && mst_w_ready_i) begin
      g = set_bit(slv_w_ready_o);
      if (w_ent >= N_ENT || g < 0) fail_note("W beat passed with no pending write");
      else begin
        chk_port("W source port", axi_wmux_pkg::port_idx_t'(g), tbl[w_ent].port);
        chk_data("mst_w_data_o", mst_w_data_o, wdata[w_ent][w_beat]);
        chk_bit("mst_w_last_o", mst_w_last_o, w_beat == int'(tbl[w_ent].beats) - 1);
        port_beat[g]++;
        if (port_beat[g] == int'(tbl[port_w[g]].beats)) begin
          port_w[g]    = next_ent(g, port_w[g] + 1);
          port_beat[g] = 0;
        end
        w_beat++;
        if (w_beat == int'(tbl[w_ent].beats)) begin
          b_q.push_back(w_ent);
          w_ent++;
          w_beat = 0;
        end
      end
    end
    if (mst_b_valid_i) begin
      e = b_q[0];
      g = set_bit(slv_b_valid_o);
      chk_bit("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i[tbl[e].port]);
      if (g < 0) fail_note("B response reached no slave port");
      else begin
        chk_port("B target port", axi_wmux_pkg::port_idx_t'(g), tbl[e].port);
        chk_sid("slv_b_id_o", slv_b_id_o[g], tbl[e].sid);
        chk_resp("slv_b_resp_o", slv_b_resp_o[g], tbl[e].resp);
      end
      if (mst_b_ready_o) begin
        void'(b_q.pop_front());
        b_cnt++;
        tests++;
        if (errors == err_mark) pass_cnt++;
        $display("test %0d port %0d beats %0d: %s", e, tbl[e].port, tbl[e].beats,
                 (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int seed_ret;
    seed_ret = $urandom(SEED);
    // Ports in round-robin order, so table order is the expected AW order
    tbl[0] = '{2'd0, 4'h3, 32'h0000_1000, 3'd2, 2'b00};
    tbl[1] = '{2'd1, 4'h3, 32'h0000_2004, 3'd1, 2'b10};
    tbl[2] = '{2'd2, 4'hA, 32'h0000_3008, 3'd4, 2'b00};
    tbl[3] = '{2'd3, 4'h0, 32'h0000_400C, 3'd3, 2'b01};
    tbl[4] = '{2'd0, 4'h7, 32'h0000_5010, 3'd1, 2'b11};
    tbl[5] = '{2'd1, 4'hF, 32'h0000_6014, 3'd3, 2'b00};
    tbl[6] = '{2'd2, 4'h5, 32'h0000_7018, 3'd2, 2'b10};
    tbl[7] = '{2'd3, 4'h9, 32'h0000_801C, 3'd4, 2'b00};
    tbl[8] = '{2'd0, 4'h1, 32'h0000_9020, 3'd3, 2'b01};
    tbl[9] = '{2'd1, 4'hC, 32'h0000_A024, 3'd2, 2'b00};
    for (int e = 0; e < N_ENT; e++) begin
      aw_done[e] = 1'b0;
      for (int b = 0; b < 4; b++) wdata[e][b] = $urandom;
    end
    for (int p = 0; p < NP; p++) begin
      port_aw[p]   = N_ENT;  // Hold AWs back through reset
      port_w[p]    = next_ent(p, 0);
      port_beat[p] = 0;
    end
    reset_i = 1'b1;
    drive_inputs();
    repeat (16) begin
      @(posedge clk_i);
      #1;
      if (mst_aw_valid_o || mst_w_valid_o || slv_b_valid_o != '0) begin
        fail_note("Output valid high during reset");
      end
    end
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    #1;
    if (mst_aw_valid_o || mst_w_valid_o || slv_b_valid_o != '0) begin
      fail_note("Output valid high right after reset");
    end
    tests++;
    if (errors == err_mark) pass_cnt++;
    $display("test reset: %s", (errors == err_mark) ? "ok" : "FAILED");
    err_mark = errors;
    for (int p = 0; p < NP; p++) port_aw[p] = next_ent(p, 0);
    while (b_cnt < N_ENT) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      observe();
    end
    $display("tests %0d passed %0d errors %0d", tests, pass_cnt, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hw/axi_wmux_pkg.sv
hw/aw_rr_arbiter.sv
hw/aw_lock_fsm.sv
hw/w_route_fifo.sv
hw/w_b_steer.sv
hw/axi_wmux_top.sv
bench/axi_wmux_checker.sv
bench/axi_wmux_tb.sv

//--- Makefile
# Verilator build and run of the write mux testbench

VERILATOR ?= verilator
TOP       ?= axi_wmux_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
